// ==== rtl/elem_beat_if.sv ====
////////////////////
// one decoded beat, driven by decode and read by execute
////////////////////
`timescale 1ns/1ps
`include "vec_elem_defs.svh"

interface elem_beat_if import vec_elem_pkg::*; ();

    elem_op_e                op;
    eew_e                    eew;
    logic                    first;
    logic                    last;
    logic [`ELEM_W-1:0]      elem;
    logic [`ELEM_W-1:0]      init;
    logic                    mask_bit;
    // inside vl and enabled by v0
    logic                    active;
    logic                    is_reduction;
    logic [`BYTE_MASK_W-1:0] write_en;

    modport src (
        output op, eew, first, last, elem, init, mask_bit, active, is_reduction, write_en
    );

    modport dst (
        input  op, eew, first, last, elem, init, mask_bit, active, is_reduction, write_en
    );

endinterface

// ==== rtl/elem_decode.sv ====
////////////////////
// decode of one input beat
// forms the v0 enable, the reduction class and the byte write enables
////////////////////
`timescale 1ns/1ps
`include "vec_elem_defs.svh"

module elem_decode import vec_elem_pkg::*; (
    input  elem_op_e           in_op_i,
    input  eew_e               in_eew_i,
    input  logic               in_first_i,
    input  logic               in_last_i,
    input  logic               in_vl_mask_i,
    input  logic               in_vl_0_i,
    input  logic               in_masked_i,
    input  logic               in_v0_i,
    input  logic [`ELEM_W-1:0] in_op1_i,
    input  logic [`ELEM_W-1:0] in_op2_i,
    elem_beat_if.src           beat
);

    logic v0_en;
    logic reduction;
    logic write;

    // unmasked instructions see every element as enabled
    assign v0_en     = in_v0_i | ~in_masked_i;
    assign reduction = in_op_i inside {ELEM_VREDSUM, ELEM_VREDAND, ELEM_VREDOR,
                                       ELEM_VREDXOR, ELEM_VREDMINU, ELEM_VREDMIN,
                                       ELEM_VREDMAXU, ELEM_VREDMAX};

    always_comb begin
        if (reduction) begin
            // a reduction writes its scalar unless vl is zero
            write = ~in_vl_0_i;
        end else if (in_op_i == ELEM_VCOMPRESS) begin
            write = in_vl_mask_i;
        end else begin
            write = in_vl_mask_i & v0_en;
        end
    end

    assign beat.op           = in_op_i;
    assign beat.eew          = in_eew_i;
    assign beat.first        = in_first_i;
    assign beat.last         = in_last_i;
    assign beat.elem         = in_op1_i;
    assign beat.init         = in_op2_i;
    // mask operations take their bit from the lsb of op2
    assign beat.mask_bit     = in_op2_i[0];
    assign beat.active       = in_vl_mask_i & v0_en;
    assign beat.is_reduction = reduction;
    assign beat.write_en     = {`BYTE_MASK_W{write}};

endmodule

// ==== rtl/elem_execute.sv ====
////////////////////
// execute stage, one result per beat from the decoded operands
// holds the running element counter of vid, vpopc, viota and vfirst
////////////////////
`timescale 1ns/1ps
`include "vec_elem_defs.svh"

module elem_execute import vec_elem_pkg::*; (
    input  logic        clk_i,
    input  logic        async_rst_ni,
    elem_beat_if.dst    beat,
    elem_result_if.exec res
);

    logic [`ELEM_W-1:0] counter_q;
    logic [`ELEM_W-1:0] count_val;
    logic               counter_inc;
    logic               none_seen;
    logic [`ELEM_W-1:0] op_val;
    logic               op_valid;
    logic [`ELEM_W-1:0] red_base;
    logic [`ELEM_W-1:0] red_val;
    logic [`ELEM_W-1:0] lane;
    logic [`ELEM_W:0]   key_a;
    logic [`ELEM_W:0]   key_b;
    logic               cmp_signed;
    logic               take_max;
    logic               elem_wins;

    // widen the low eew bits to a comparable signed key
    function automatic logic [`ELEM_W:0] cmp_key(
        input logic [`ELEM_W-1:0] v,
        input eew_e               eew,
        input logic               sgn
    );
        logic [`ELEM_W:0] k;
        case (eew)
            EEW_8:   k = {{25{sgn & v[7]}}, v[7:0]};
            EEW_16:  k = {{17{sgn & v[15]}}, v[15:0]};
            EEW_32:  k = {sgn & v[31], v};
            default: k = '0;
        endcase
        return k;
    endfunction

    ////////////////////
    // running counter

    assign count_val = beat.first ? '0 : counter_q;
    // acc msb still set means vfirst has found no set bit yet
    assign none_seen = res.acc[`ELEM_W-1] & ~beat.mask_bit;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            counter_q <= '0;
        end else if (res.ready) begin
            counter_q <= count_val + {{(`ELEM_W-1){1'b0}}, counter_inc};
        end
    end

    ////////////////////
    // element operations

    always_comb begin
        counter_inc = 1'b0;
        op_val      = '0;
        op_valid    = 1'b0;
        case (beat.op)
            ELEM_XMV: begin
                case (beat.eew)
                    EEW_8:   op_val = {{24{beat.elem[7]}}, beat.elem[7:0]};
                    EEW_16:  op_val = {{16{beat.elem[15]}}, beat.elem[15:0]};
                    EEW_32:  op_val = beat.elem;
                    default: op_val = '0;
                endcase
            end
            ELEM_VID: begin
                counter_inc = 1'b1;
                op_val      = count_val;
                op_valid    = 1'b1;
            end
            ELEM_VPOPC, ELEM_VIOTA: begin
                // only enabled set bits add to the count
                counter_inc = beat.mask_bit & beat.active;
                op_val      = count_val;
                op_valid    = 1'b1;
            end
            ELEM_VFIRST: begin
                counter_inc = beat.first ? ~beat.mask_bit : none_seen;
                if (beat.first) begin
                    op_val = {`ELEM_W{~beat.mask_bit}};
                end else begin
                    op_val = none_seen ? '1 : counter_q;
                end
                op_valid = 1'b1;
            end
            ELEM_VCOMPRESS: begin
                op_val   = beat.elem;
                op_valid = beat.mask_bit;
            end
            default: ;
        endcase
    end

    ////////////////////
    // reductions

    assign red_base   = beat.first ? beat.init : res.acc;
    assign cmp_signed = beat.op inside {ELEM_VREDMIN, ELEM_VREDMAX};
    assign take_max   = beat.op inside {ELEM_VREDMAXU, ELEM_VREDMAX};
    assign key_a      = cmp_key(beat.elem, beat.eew, cmp_signed);
    assign key_b      = cmp_key(red_base, beat.eew, cmp_signed);
    assign elem_wins  = take_max ? ($signed(key_b) < $signed(key_a))
                                 : ($signed(key_a) < $signed(key_b));

    always_comb begin
        case (beat.eew)
            EEW_8:   lane = 32'h0000_00ff;
            EEW_16:  lane = 32'h0000_ffff;
            EEW_32:  lane = 32'hffff_ffff;
            default: lane = '0;
        endcase
    end

    always_comb begin
        red_val = red_base;
        if (beat.active) begin
            case (beat.op)
                ELEM_VREDSUM: red_val = beat.elem + red_base;
                ELEM_VREDAND: red_val = beat.elem & red_base;
                ELEM_VREDOR:  red_val = beat.elem | red_base;
                ELEM_VREDXOR: red_val = beat.elem ^ red_base;
                ELEM_VREDMINU, ELEM_VREDMIN, ELEM_VREDMAXU, ELEM_VREDMAX: begin
                    // narrow min and max keep the upper bits of the base
                    if (elem_wins) begin
                        red_val = (red_base & ~lane) | (beat.elem & lane);
                    end
                end
                default: ;
            endcase
        end
    end

    assign res.result       = beat.is_reduction ? red_val : op_val;
    assign res.result_valid = beat.is_reduction ? beat.last : op_valid;
    assign res.result_mask  = beat.write_en;
    assign res.fire         = res.ready;
    assign res.eew          = beat.eew;
    assign res.first        = beat.first;
    assign res.last         = beat.last;
    assign res.is_xmv       = beat.op == ELEM_XMV;

endmodule

// ==== rtl/elem_result.sv ====
////////////////////
// output buffer of the element unit
// tracks the destination byte count, register index and scalar write-back
////////////////////
`timescale 1ns/1ps
`include "vec_elem_defs.svh"

module elem_result import vec_elem_pkg::*; (
    input  logic                    clk_i,
    input  logic                    async_rst_ni,
    elem_result_if.buffer           res,
    input  logic                    in_valid_i,
    input  logic                    in_xreg_i,
    input  logic [`VREG_ADDR_W-1:0] in_vd_i,
    input  emul_e                   in_emul_i,
    input  logic                    out_ready_i,
    output logic                    in_ready_o,
    output logic                    out_valid_o,
    output logic                    out_res_valid_o,
    output logic [`ELEM_W-1:0]      out_res_o,
    output logic [`BYTE_MASK_W-1:0] out_mask_o,
    output logic                    out_xreg_valid_o,
    output logic [`ELEM_W-1:0]      out_xreg_data_o,
    output logic [`VREG_ADDR_W-1:0] out_xreg_addr_o,
    output logic [`VREG_ADDR_W-1:0] out_vd_o,
    output logic                    out_vd_store_o,
    output vd_count_u               out_count_o
);

    logic                    valid_q;
    logic [`ELEM_W-1:0]      result_q;
    logic [`BYTE_MASK_W-1:0] mask_q;
    logic                    rvalid_q;
    eew_e                    eew_q;
    emul_e                   emul_q;
    logic                    first_q;
    logic                    last_q;
    logic                    xmv_q;
    logic                    xreg_q;
    logic [`VREG_ADDR_W-1:0] vd_q;
    logic                    has_valid_q;
    logic                    has_valid_d;
    vd_count_u               count_q;
    vd_count_u               count_d;
    logic [`VD_COUNT_W-1:0]  count_step;
    logic [`VD_COUNT_W-1:0]  count_init;
    logic                    res_valid;
    logic                    first_valid;

    ////////////////////
    // buffer stage

    // buffer frees up when empty or when its beat leaves this cycle
    assign in_ready_o = ~valid_q | out_ready_i;
    assign res.ready  = in_valid_i & in_ready_o;
    assign res.acc    = result_q;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (res.fire) begin
            result_q <= res.result;
            mask_q   <= res.result_mask;
            rvalid_q <= res.result_valid;
            eew_q    <= res.eew;
            first_q  <= res.first;
            last_q   <= res.last;
            xmv_q    <= res.is_xmv;
            xreg_q   <= in_xreg_i;
            vd_q     <= in_vd_i;
            emul_q   <= in_emul_i;
        end
    end

    ////////////////////
    // destination bookkeeping

    assign res_valid   = valid_q & rvalid_q;
    assign first_valid = res_valid & (first_q | ~has_valid_q);

    always_comb begin
        has_valid_d = first_q ? 1'b0 : has_valid_q;
        if (res_valid) begin
            has_valid_d = 1'b1;
        end
    end

    // count points at the last byte written so far
    always_comb begin
        case (eew_q)
            EEW_8: begin
                count_step = `VD_COUNT_W'(1);
                count_init = `VD_COUNT_W'(0);
            end
            EEW_16: begin
                count_step = `VD_COUNT_W'(2);
                count_init = `VD_COUNT_W'(1);
            end
            EEW_32: begin
                count_step = `VD_COUNT_W'(4);
                count_init = `VD_COUNT_W'(3);
            end
            default: begin
                count_step = '0;
                count_init = '0;
            end
        endcase
        count_d.whole = count_q.whole + (res_valid ? count_step : '0);
        if (first_valid) begin
            count_d.whole = count_init;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            count_q     <= '0;
            has_valid_q <= 1'b0;
        end else if (out_valid_o & out_ready_i) begin
            count_q     <= count_d;
            has_valid_q <= has_valid_d;
        end
    end

    // register of the group selected by the upper count bits
    always_comb begin
        case (emul_q)
            EMUL_1:  out_vd_o = vd_q;
            EMUL_2:  out_vd_o = vd_q | {4'b0, count_d.part.mul[0]};
            EMUL_4:  out_vd_o = vd_q | {3'b0, count_d.part.mul[1:0]};
            EMUL_8:  out_vd_o = vd_q | {2'b0, count_d.part.mul};
            default: out_vd_o = '0;
        endcase
    end

    assign out_vd_store_o   = ~xreg_q & res_valid & (count_d.part.low == '1);
    assign out_count_o      = count_d;
    assign out_valid_o      = valid_q;
    assign out_res_valid_o  = res_valid;
    assign out_res_o        = result_q;
    assign out_mask_o       = mask_q;
    // xmv writes its scalar on the first beat, the others on the last
    assign out_xreg_valid_o = valid_q & xreg_q & (xmv_q ? first_q : last_q);
    assign out_xreg_data_o  = result_q;
    assign out_xreg_addr_o  = vd_q;

endmodule

// ==== rtl/elem_result_if.sv ====
////////////////////
// computed result from execute into the output buffer, buffered value back
////////////////////
`timescale 1ns/1ps
`include "vec_elem_defs.svh"

interface elem_result_if import vec_elem_pkg::*; ();

    logic [`ELEM_W-1:0]      result;
    logic                    result_valid;
    logic [`BYTE_MASK_W-1:0] result_mask;
    logic                    fire;
    // beat control kept alongside the result
    eew_e                    eew;
    logic                    first;
    logic                    last;
    logic                    is_xmv;
    // last buffered result, base of reductions and vfirst
    logic [`ELEM_W-1:0]      acc;
    // high when the input beat is taken this cycle
    logic                    ready;

    modport exec (
        output result, result_valid, result_mask, fire, eew, first, last, is_xmv,
        input  acc, ready
    );

    modport buffer (
        input  result, result_valid, result_mask, fire, eew, first, last, is_xmv,
        output acc, ready
    );

endinterface

// ==== rtl/vec_elem_defs.svh ====
////////////////////
// width constants of the vector element unit
// included by the package and by every RTL file that sizes a port
////////////////////
`ifndef VEC_ELEM_DEFS_SVH
`define VEC_ELEM_DEFS_SVH

// vector register width in bits
`define VREG_W 128
// element and scalar register width
`define ELEM_W 32
// scalar and vector register address
`define VREG_ADDR_W 5
// byte enables of one result word
`define BYTE_MASK_W 4
// destination byte count, log2 of register bytes plus 3 group bits
`define VD_COUNT_W 7

`endif

// ==== rtl/vec_elem_pkg.sv ====
////////////////////
// types shared by the element unit modules
// import with a wildcard in the module header
////////////////////
`include "vec_elem_defs.svh"

package vec_elem_pkg;

    // operations handled by the element unit
    typedef enum logic [3:0] {
        ELEM_XMV       = 4'd0,
        ELEM_VID       = 4'd1,
        ELEM_VPOPC     = 4'd2,
        ELEM_VIOTA     = 4'd3,
        ELEM_VFIRST    = 4'd4,
        ELEM_VCOMPRESS = 4'd5,
        ELEM_VREDSUM   = 4'd6,
        ELEM_VREDAND   = 4'd7,
        ELEM_VREDOR    = 4'd8,
        ELEM_VREDXOR   = 4'd9,
        ELEM_VREDMINU  = 4'd10,
        ELEM_VREDMIN   = 4'd11,
        ELEM_VREDMAXU  = 4'd12,
        ELEM_VREDMAX   = 4'd13
    } elem_op_e;

    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } eew_e;

    typedef enum logic [1:0] {
        EMUL_1 = 2'd0,
        EMUL_2 = 2'd1,
        EMUL_4 = 2'd2,
        EMUL_8 = 2'd3
    } emul_e;

    // byte count into the destination group, seen whole or as register and byte
    typedef union packed {
        logic [`VD_COUNT_W-1:0] whole;
        struct packed {
            logic [2:0]                   mul;
            logic [$clog2(`VREG_W/8)-1:0] low;
        } part;
    } vd_count_u;

endpackage

// ==== rtl/vec_elem_unit.sv ====
////////////////////
// top level of the vector element unit
// valid/ready beats in, one buffered result per beat out
////////////////////
`timescale 1ns/1ps
`include "vec_elem_defs.svh"

module vec_elem_unit import vec_elem_pkg::*; (
    input  logic                    clk_i,
    input  logic                    async_rst_ni,
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    input  elem_op_e                in_op_i,
    input  eew_e                    in_eew_i,
    input  emul_e                   in_emul_i,
    input  logic                    in_first_i,
    input  logic                    in_last_i,
    input  logic                    in_vl_mask_i,
    input  logic                    in_vl_0_i,
    input  logic                    in_masked_i,
    input  logic                    in_v0_i,
    input  logic                    in_xreg_i,
    input  logic [`VREG_ADDR_W-1:0] in_vd_i,
    input  logic [`ELEM_W-1:0]      in_op1_i,
    input  logic [`ELEM_W-1:0]      in_op2_i,
    output logic                    out_valid_o,
    input  logic                    out_ready_i,
    output logic                    out_res_valid_o,
    output logic [`ELEM_W-1:0]      out_res_o,
    output logic [`BYTE_MASK_W-1:0] out_mask_o,
    output logic                    out_xreg_valid_o,
    output logic [`ELEM_W-1:0]      out_xreg_data_o,
    output logic [`VREG_ADDR_W-1:0] out_xreg_addr_o,
    output logic [`VREG_ADDR_W-1:0] out_vd_o,
    output logic                    out_vd_store_o,
    output vd_count_u               out_count_o
);

    elem_beat_if   beat_if ();
    elem_result_if res_if ();

    elem_decode decode_inst (
        .in_op_i      (in_op_i),
        .in_eew_i     (in_eew_i),
        .in_first_i   (in_first_i),
        .in_last_i    (in_last_i),
        .in_vl_mask_i (in_vl_mask_i),
        .in_vl_0_i    (in_vl_0_i),
        .in_masked_i  (in_masked_i),
        .in_v0_i      (in_v0_i),
        .in_op1_i     (in_op1_i),
        .in_op2_i     (in_op2_i),
        .beat         (beat_if.src)
    );

    elem_execute execute_inst (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .beat         (beat_if.dst),
        .res          (res_if.exec)
    );

    elem_result result_inst (
        .clk_i            (clk_i),
        .async_rst_ni     (async_rst_ni),
        .res              (res_if.buffer),
        .in_valid_i       (in_valid_i),
        .in_xreg_i        (in_xreg_i),
        .in_vd_i          (in_vd_i),
        .in_emul_i        (in_emul_i),
        .out_ready_i      (out_ready_i),
        .in_ready_o       (in_ready_o),
        .out_valid_o      (out_valid_o),
        .out_res_valid_o  (out_res_valid_o),
        .out_res_o        (out_res_o),
        .out_mask_o       (out_mask_o),
        .out_xreg_valid_o (out_xreg_valid_o),
        .out_xreg_data_o  (out_xreg_data_o),
        .out_xreg_addr_o  (out_xreg_addr_o),
        .out_vd_o         (out_vd_o),
        .out_vd_store_o   (out_vd_store_o),
        .out_count_o      (out_count_o)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, decide on the log contents
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vec_elem_unit.f \
    --top-module tb_vec_elem_unit -o tb_vec_elem_unit > build.log 2>&1 \
    && ./obj_dir/tb_vec_elem_unit > sim.log 2>&1

grep -q '^TB PASSED$' sim.log \
    && echo "simulation finished without errors" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== sim/elem_input.txt ====
# op eew emul first last vl_mask vl_0 masked v0 xreg vd op1 op2 (all hex)
# then expected: res_valid res mask xreg_valid vd store
# xmv sign extension
0 0 0 1 1 1 0 0 0 1 03 000000f5 00000000  0 fffffff5 f 1 03 0
0 1 0 1 1 1 0 0 0 1 07 12348001 00000000  0 ffff8001 f 1 07 0
0 0 0 1 1 1 0 0 0 1 01 0000007f 00000000  0 0000007f f 1 01 0
# vid, masked with v0 = 1 0 1 1
1 2 0 1 0 1 0 1 1 1 02 00000000 00000000  1 00000000 f 0 02 0
1 2 0 0 0 1 0 1 0 1 02 00000000 00000000  1 00000001 0 0 02 0
1 2 0 0 0 1 0 1 1 1 02 00000000 00000000  1 00000002 f 0 02 0
1 2 0 0 1 1 0 1 1 1 02 00000000 00000000  1 00000003 f 1 02 0
# vpopc, mask bits 1 0 1 1
2 2 0 1 0 1 0 0 0 1 0a 00000000 00000001  1 00000000 f 0 0a 0
2 2 0 0 0 1 0 0 0 1 0a 00000000 00000000  1 00000001 f 0 0a 0
2 2 0 0 0 1 0 0 0 1 0a 00000000 00000001  1 00000001 f 0 0a 0
2 2 0 0 1 1 0 0 0 1 0a 00000000 00000001  1 00000002 f 1 0a 0
# viota, v0 1 1 0 1, mask bits 1 1 1 0
3 2 0 1 0 1 0 1 1 1 0c 00000000 00000001  1 00000000 f 0 0c 0
3 2 0 0 0 1 0 1 1 1 0c 00000000 00000001  1 00000001 f 0 0c 0
3 2 0 0 0 1 0 1 0 1 0c 00000000 00000001  1 00000002 0 0 0c 0
3 2 0 0 1 1 0 1 1 1 0c 00000000 00000000  1 00000002 f 1 0c 0
# vfirst, first set bit at index 2
4 2 0 1 0 1 0 0 0 1 0e 00000000 00000000  1 ffffffff f 0 0e 0
4 2 0 0 0 1 0 0 0 1 0e 00000000 00000000  1 ffffffff f 0 0e 0
4 2 0 0 0 1 0 0 0 1 0e 00000000 00000001  1 00000002 f 0 0e 0
4 2 0 0 1 1 0 0 0 1 0e 00000000 00000000  1 00000002 f 1 0e 0
# vfirst with no set bit
4 2 0 1 0 1 0 0 0 1 0f 00000000 00000000  1 ffffffff f 0 0f 0
4 2 0 0 0 1 0 0 0 1 0f 00000000 00000000  1 ffffffff f 0 0f 0
4 2 0 0 1 1 0 0 0 1 0f 00000000 00000000  1 ffffffff f 1 0f 0
# sum, and, or, xor over two beats
6 2 0 1 0 1 0 0 0 1 10 00000005 00000010  0 00000015 f 0 10 0
6 2 0 0 1 1 0 0 0 1 10 fffffffe 00000000  1 00000013 f 1 10 0
7 2 0 1 0 1 0 0 0 1 11 f0f0f0ff ffffffff  0 f0f0f0ff f 0 11 0
7 2 0 0 1 1 0 0 0 1 11 0ff0ffff 00000000  1 00f0f0ff f 1 11 0
8 2 0 1 0 1 0 0 0 1 12 00000100 00000001  0 00000101 f 0 12 0
8 2 0 0 1 1 0 0 0 1 12 00010000 00000000  1 00010101 f 1 12 0
9 2 0 1 0 1 0 0 0 1 13 00ff00ff 0000ffff  0 00ffff00 f 0 13 0
9 2 0 0 1 1 0 0 0 1 13 ffffffff 00000000  1 ff0000ff f 1 13 0
# signed against unsigned min and max at each eew
b 0 0 1 1 1 0 0 0 1 14 000000f0 12340010  1 123400f0 f 1 14 0
a 0 0 1 1 1 0 0 0 1 14 000000f0 12340010  1 12340010 f 1 14 0
c 1 0 1 1 1 0 0 0 1 15 0000ff00 00001000  1 0000ff00 f 1 15 0
d 1 0 1 1 1 0 0 0 1 15 0000ff00 00001000  1 00001000 f 1 15 0
b 2 0 1 1 1 0 0 0 1 16 80000000 00000001  1 80000000 f 1 16 0
a 2 0 1 1 1 0 0 0 1 16 80000000 00000001  1 00000001 f 1 16 0
# vcompress into a group of 2 registers at v4
5 2 1 1 0 1 0 0 0 0 04 00000100 00000001  1 00000100 f 0 04 0
5 2 1 0 0 1 0 0 0 0 04 00000101 00000000  0 00000101 f 0 04 0
5 2 1 0 0 1 0 0 0 0 04 00000102 00000001  1 00000102 f 0 04 0
5 2 1 0 0 1 0 0 0 0 04 00000103 00000001  1 00000103 f 0 04 0
5 2 1 0 0 1 0 0 0 0 04 00000104 00000001  1 00000104 f 0 04 1
5 2 1 0 0 1 0 0 0 0 04 00000105 00000000  0 00000105 f 0 04 0
5 2 1 0 0 1 0 0 0 0 04 00000106 00000001  1 00000106 f 0 05 0
5 2 1 0 0 1 0 0 0 0 04 00000107 00000001  1 00000107 f 0 05 0
5 2 1 0 0 1 0 0 0 0 04 00000108 00000001  1 00000108 f 0 05 0
5 2 1 0 1 1 0 0 0 0 04 00000109 00000001  1 00000109 f 0 05 1

// ==== sim/tb_vec_elem_unit.sv ====
////////////////////
// self-checking testbench of the vector element unit
// beats and expected outputs come from sim/elem_input.txt
////////////////////
`timescale 1ns/1ps
`include "vec_elem_defs.svh"

module tb_vec_elem_unit import vec_elem_pkg::*; ();

    localparam int MAX_BEATS  = 64;
    localparam int NUM_FIELDS = 19;
    localparam int CLK_PERIOD = 8;
    // column positions in the data file
    localparam int F_OP    = 0;
    localparam int F_EEW   = 1;
    localparam int F_EMUL  = 2;
    localparam int F_FIRST = 3;
    localparam int F_LAST  = 4;
    localparam int F_VLM   = 5;
    localparam int F_VL0   = 6;
    localparam int F_MSK   = 7;
    localparam int F_V0    = 8;
    localparam int F_XREG  = 9;
    localparam int F_VD    = 10;
    localparam int F_OP1   = 11;
    localparam int F_OP2   = 12;
    localparam int F_RV    = 13;
    localparam int F_RES   = 14;
    localparam int F_MASK  = 15;
    localparam int F_XV    = 16;
    localparam int F_EVD   = 17;
    localparam int F_ST    = 18;

    logic                    clk_i;
    logic                    async_rst_ni;
    logic                    in_valid_i;
    logic                    in_ready_o;
    elem_op_e                in_op_i;
    eew_e                    in_eew_i;
    emul_e                   in_emul_i;
    logic                    in_first_i;
    logic                    in_last_i;
    logic                    in_vl_mask_i;
    logic                    in_vl_0_i;
    logic                    in_masked_i;
    logic                    in_v0_i;
    logic                    in_xreg_i;
    logic [`VREG_ADDR_W-1:0] in_vd_i;
    logic [`ELEM_W-1:0]      in_op1_i;
    logic [`ELEM_W-1:0]      in_op2_i;
    logic                    out_valid_o;
    logic                    out_ready_i;
    logic                    out_res_valid_o;
    logic [`ELEM_W-1:0]      out_res_o;
    logic [`BYTE_MASK_W-1:0] out_mask_o;
    logic                    out_xreg_valid_o;
    logic [`ELEM_W-1:0]      out_xreg_data_o;
    logic [`VREG_ADDR_W-1:0] out_xreg_addr_o;
    logic [`VREG_ADDR_W-1:0] out_vd_o;
    logic                    out_vd_store_o;
    vd_count_u               out_count_o;

    logic [31:0] beat_tab [0:MAX_BEATS-1][0:NUM_FIELDS-1];
    int          n_beats;
    int          n_out;
    bit          loaded;
    int          seed;
    // indices of accepted beats still waiting for their output
    int          exp_q[$];
    // destination byte count model, advanced per output beat
    logic [`VD_COUNT_W-1:0] exp_count;
    bit                     exp_has_valid;

    vec_elem_unit vec_elem_unit_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else
            fail_run($sformatf("ERR time=%0t signal=%s expected=%h actual=%h",
                               $time, name, exp, act));
    endtask

    task automatic load_beats();
        int    fd;
        int    n;
        string line;
        int    f [0:NUM_FIELDS-1];
        fd = $fopen("sim/elem_input.txt", "r");
        assert (fd != 0) else fail_run("could not open the stimulus file sim/elem_input.txt");
        n_beats = 0;
        while (!$feof(fd) && n_beats < MAX_BEATS) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                            f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
                if (n == NUM_FIELDS) begin
                    for (int k = 0; k < NUM_FIELDS; k++) begin
                        beat_tab[n_beats][k] = f[k];
                    end
                    n_beats++;
                end
            end
        end
        $fclose(fd);
        assert (n_beats > 0) else fail_run("the stimulus file holds no beats");
    endtask

    task automatic drive_beat(input int i);
        in_op_i      = elem_op_e'(beat_tab[i][F_OP][3:0]);
        in_eew_i     = eew_e'(beat_tab[i][F_EEW][1:0]);
        in_emul_i    = emul_e'(beat_tab[i][F_EMUL][1:0]);
        in_first_i   = beat_tab[i][F_FIRST][0];
        in_last_i    = beat_tab[i][F_LAST][0];
        in_vl_mask_i = beat_tab[i][F_VLM][0];
        in_vl_0_i    = beat_tab[i][F_VL0][0];
        in_masked_i  = beat_tab[i][F_MSK][0];
        in_v0_i      = beat_tab[i][F_V0][0];
        in_xreg_i    = beat_tab[i][F_XREG][0];
        in_vd_i      = beat_tab[i][F_VD][`VREG_ADDR_W-1:0];
        in_op1_i     = beat_tab[i][F_OP1];
        in_op2_i     = beat_tab[i][F_OP2];
        in_valid_i   = 1'b1;
    endtask

    // an element of eew bytes moves the count by that many bytes,
    // the first written element of an instruction ends at its own last byte
    task automatic advance_count(input int i);
        logic [`VD_COUNT_W-1:0] bytes;
        bytes = `VD_COUNT_W'(1) << beat_tab[i][F_EEW][1:0];
        if (beat_tab[i][F_FIRST][0]) begin
            exp_has_valid = 1'b0;
        end
        if (beat_tab[i][F_RV][0]) begin
            exp_count     = exp_has_valid ? exp_count + bytes : bytes - 1'b1;
            exp_has_valid = 1'b1;
        end
    endtask

    task automatic compare_outputs(input int i);
        advance_count(i);
        check_field("out_res_valid_o", beat_tab[i][F_RV], 32'(out_res_valid_o));
        check_field("out_res_o", beat_tab[i][F_RES], out_res_o);
        check_field("out_mask_o", beat_tab[i][F_MASK], 32'(out_mask_o));
        check_field("out_xreg_valid_o", beat_tab[i][F_XV], 32'(out_xreg_valid_o));
        check_field("out_xreg_data_o", beat_tab[i][F_RES], out_xreg_data_o);
        check_field("out_xreg_addr_o", beat_tab[i][F_VD], 32'(out_xreg_addr_o));
        check_field("out_vd_o", beat_tab[i][F_EVD], 32'(out_vd_o));
        check_field("out_vd_store_o", beat_tab[i][F_ST], 32'(out_vd_store_o));
        check_field("out_count_o", 32'(exp_count), 32'(out_count_o.whole));
    endtask

    ////////////////////
    // output side

    initial begin
        seed        = 41520;
        out_ready_i = 1'b0;
        @(posedge async_rst_ni);
        forever begin
            @(posedge clk_i);
            #1;
            // stall about one cycle in four
            out_ready_i = ($random(seed) & 3) != 0;
        end
    end

    // sampled at the falling edge where outputs are settled
    initial begin
        int idx;
        n_out         = 0;
        exp_count     = '0;
        exp_has_valid = 1'b0;
        forever begin
            @(negedge clk_i);
            if (out_valid_o && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    fail_run("an output beat appeared with no accepted input beat");
                end else begin
                    idx = exp_q.pop_front();
                    compare_outputs(idx);
                    n_out++;
                end
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (n_beats * 40) @(posedge clk_i);
        fail_run("watchdog: the run timed out before all output beats arrived");
    end

    ////////////////////
    // input side

    initial begin
        async_rst_ni = 1'b0;
        in_valid_i   = 1'b0;
        in_op_i      = ELEM_XMV;
        in_eew_i     = EEW_8;
        in_emul_i    = EMUL_1;
        in_first_i   = 1'b0;
        in_last_i    = 1'b0;
        in_vl_mask_i = 1'b0;
        in_vl_0_i    = 1'b0;
        in_masked_i  = 1'b0;
        in_v0_i      = 1'b0;
        in_xreg_i    = 1'b0;
        in_vd_i      = '0;
        in_op1_i     = '0;
        in_op2_i     = '0;
        load_beats();
        loaded = 1'b1;
        repeat (5) @(posedge clk_i);
        #1 async_rst_ni = 1'b1;
        for (int i = 0; i < n_beats; i++) begin
            @(posedge clk_i);
            #1;
            drive_beat(i);
            // the beat is taken at the next rising edge once ready is high
            do begin
                @(negedge clk_i);
            end while (!in_ready_o);
            exp_q.push_back(i);
        end
        @(posedge clk_i);
        #1 in_valid_i = 1'b0;
        wait (n_out == n_beats);
        repeat (4) @(negedge clk_i);
        if (!out_valid_o) begin
            $display("TB PASSED");
            $finish;
        end else begin
            fail_run("the output stayed valid after every accepted beat had been checked");
        end
    end

endmodule

// ==== vec_elem_unit.f ====
+incdir+rtl
rtl/vec_elem_pkg.sv
rtl/elem_beat_if.sv
rtl/elem_result_if.sv
rtl/elem_decode.sv
rtl/elem_execute.sv
rtl/elem_result.sv
rtl/vec_elem_unit.sv
sim/tb_vec_elem_unit.sv
